//--- hdl/dma_pkg.sv
/*
 * Shared widths and types of the DMA transport datapath.
 * The data word is 32 bits wide with four byte lanes.
 * Transfer lengths run from 1 to 255 bytes, and addresses are byte addresses.
 */
package dma_pkg;

    localparam int unsigned DataWidth   = 32;
    localparam int unsigned StrbWidth   = DataWidth / 8;
    localparam int unsigned AddrWidth   = 16;
    localparam int unsigned LenWidth    = 8;
    localparam int unsigned BufferDepth = 3;
    localparam int unsigned ShiftWidth  = $clog2(StrbWidth);
    localparam int unsigned PtrWidth    = $clog2(BufferDepth);
    localparam int unsigned CntWidth    = $clog2(BufferDepth + 1);

    typedef logic [7:0]                  byte_t;
    typedef byte_t [StrbWidth-1:0]       lane_data_t;
    typedef logic [StrbWidth-1:0]        lane_mask_t;
    typedef logic [AddrWidth-1:0]        addr_t;
    typedef logic [LenWidth-1:0]         len_t;
    typedef logic [ShiftWidth-1:0]       shift_t;
    typedef logic [PtrWidth-1:0]         ptr_t;
    typedef logic [CntWidth-1:0]         cnt_t;

    // Lanes of one word covered by a range that starts at lane off with rem bytes left
    function automatic lane_mask_t span_mask(shift_t off, len_t rem);
        lane_mask_t mask;
        mask = '0;
        for (int l = 0; l < StrbWidth; l++) begin
            mask[l] = (l >= int'(off)) && ((l - int'(off)) < int'(rem));
        end
        return mask;
    endfunction

    // Number of bytes in that span
    function automatic len_t span_bytes(shift_t off, len_t rem);
        len_t room;
        room = len_t'(StrbWidth) - len_t'(off);
        return (rem < room) ? rem : room;
    endfunction

endpackage

//--- hdl/xfer_desc_if.sv
/*
 * Descriptor link from the transfer controller to one memory port.
 * A descriptor moves when valid and ready are both high, and the
 * fields hold until then. done pulses once after the last word.
 */
`timescale 1ns/1ps

interface xfer_desc_if;

    logic           valid;
    logic           ready;
    dma_pkg::addr_t addr;
    dma_pkg::len_t  length;
    logic           done;

    modport ctrl (
        output valid,
        output addr,
        output length,
        input  ready,
        input  done
    );

    modport port (
        input  valid,
        input  addr,
        input  length,
        output ready,
        output done
    );

endinterface

//--- hdl/xfer_ctrl.sv
/*
 * Transfer controller of the DMA transport.
 * Takes one command at a time; the length must be 1 to 255 bytes and
 * the command fields must stay stable while cmd_valid_i is high.
 * Both descriptors launch the cycle after the command handshake, and
 * the transfer ends on the write side's done.
 */
`timescale 1ns/1ps

module xfer_ctrl (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             cmd_valid_i,
    output logic             cmd_ready_o,
    input  dma_pkg::addr_t   cmd_src_addr_i,
    input  dma_pkg::addr_t   cmd_dst_addr_i,
    input  dma_pkg::len_t    cmd_len_i,
    output logic             busy_o,
    output logic             done_o,
    output dma_pkg::shift_t  rd_shift_o,
    xfer_desc_if.ctrl        rd_desc,
    xfer_desc_if.ctrl        wr_desc
);

    logic           busy_q;
    logic           done_q;
    logic           rd_valid_q;
    logic           wr_valid_q;
    logic           rd_pend_q;
    logic           cmd_fire;
    dma_pkg::addr_t src_q;
    dma_pkg::addr_t dst_q;
    dma_pkg::len_t  len_q;

    assign cmd_ready_o = !busy_q && !rd_pend_q;
    assign cmd_fire    = cmd_valid_i && cmd_ready_o;

    //----------------------------------------
    // Control state
    //----------------------------------------

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            busy_q     <= 1'b0;
            done_q     <= 1'b0;
            rd_valid_q <= 1'b0;
            wr_valid_q <= 1'b0;
            rd_pend_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (cmd_fire) begin
                busy_q     <= 1'b1;
                rd_valid_q <= 1'b1;
                wr_valid_q <= 1'b1;
                rd_pend_q  <= 1'b1;
            end
            if (rd_desc.valid && rd_desc.ready) begin
                rd_valid_q <= 1'b0;
            end
            if (wr_desc.valid && wr_desc.ready) begin
                wr_valid_q <= 1'b0;
            end
            // Read side done only frees the read slot
            if (rd_desc.done) begin
                rd_pend_q <= 1'b0;
            end
            if (wr_desc.done) begin
                busy_q <= 1'b0;
                done_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (cmd_fire) begin
            src_q <= cmd_src_addr_i;
            dst_q <= cmd_dst_addr_i;
            len_q <= cmd_len_i;
        end
    end

    // Lane rotation from source alignment to destination alignment
    assign rd_shift_o = dma_pkg::shift_t'(dst_q) - dma_pkg::shift_t'(src_q);

    assign rd_desc.valid  = rd_valid_q;
    assign rd_desc.addr   = src_q;
    assign rd_desc.length = len_q;
    assign wr_desc.valid  = wr_valid_q;
    assign wr_desc.addr   = dst_q;
    assign wr_desc.length = len_q;

    assign busy_o = busy_q;
    assign done_o = done_q;

endmodule

//--- hdl/read_port.sv
/*
 * Source reader of the DMA transport.
 * Reads whole words over OBI with one read in flight, keeps only the
 * bytes of the transfer and rotates them onto the destination lanes.
 * A word is offered to the lane buffer only when all its lanes are
 * ready, so it moves in a single cycle.
 */
`timescale 1ns/1ps

module read_port (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    xfer_desc_if.port            rd_desc,
    input  dma_pkg::shift_t      rd_shift_i,
    output logic                 src_req_o,
    output dma_pkg::addr_t       src_addr_o,
    input  logic                 src_gnt_i,
    input  logic                 src_rvalid_i,
    input  dma_pkg::lane_data_t  src_rdata_i,
    output dma_pkg::lane_data_t  lane_data_o,
    output dma_pkg::lane_mask_t  lane_valid_o,
    input  dma_pkg::lane_mask_t  lane_ready_i
);

    typedef enum logic [1:0] {
        st_idle,
        st_req,
        st_resp,
        st_hold
    } state_e;

    state_e              state_q;
    dma_pkg::addr_t      addr_q;
    dma_pkg::shift_t     off_q;
    dma_pkg::len_t       rem_q;
    dma_pkg::lane_data_t rdata_q;

    dma_pkg::lane_mask_t word_mask;
    dma_pkg::len_t       word_bytes;
    dma_pkg::lane_data_t word_data;
    dma_pkg::lane_data_t rot_data;
    dma_pkg::lane_mask_t rot_mask;
    logic                offer;
    logic                push;
    logic                last;

    assign word_mask  = dma_pkg::span_mask(off_q, rem_q);
    assign word_bytes = dma_pkg::span_bytes(off_q, rem_q);
    // Fresh data goes straight through, a stalled word comes from the latch
    assign word_data  = (state_q == st_hold) ? rdata_q : src_rdata_i;

    //----------------------------------------
    // Barrel rotation onto destination lanes
    //----------------------------------------

    always_comb begin
        dma_pkg::shift_t dst_lane;
        rot_data = '0;
        rot_mask = '0;
        for (int l = 0; l < dma_pkg::StrbWidth; l++) begin
            dst_lane           = dma_pkg::shift_t'(l) + rd_shift_i;
            rot_data[dst_lane] = word_data[l];
            rot_mask[dst_lane] = word_mask[l];
        end
    end

    assign offer = ((state_q == st_resp) && src_rvalid_i) || (state_q == st_hold);
    assign push  = offer && ((lane_ready_i & rot_mask) == rot_mask);
    assign last  = rem_q <= word_bytes;

    assign lane_data_o   = rot_data;
    assign lane_valid_o  = push ? rot_mask : '0;
    assign src_req_o     = state_q == st_req;
    assign src_addr_o    = addr_q;
    assign rd_desc.ready = state_q == st_idle;
    assign rd_desc.done  = push && last;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= st_idle;
        end else begin
            unique case (state_q)
                st_idle: if (rd_desc.valid) state_q <= st_req;
                st_req:  if (src_gnt_i) state_q <= st_resp;
                default: begin
                    // Next read only after the current word has left
                    if (push) begin
                        state_q <= last ? st_idle : st_req;
                    end else if (offer) begin
                        state_q <= st_hold;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (rd_desc.valid && rd_desc.ready) begin
            addr_q <= rd_desc.addr & ~dma_pkg::addr_t'(dma_pkg::StrbWidth - 1);
            off_q  <= dma_pkg::shift_t'(rd_desc.addr);
            rem_q  <= rd_desc.length;
        end else if (push) begin
            addr_q <= addr_q + dma_pkg::addr_t'(dma_pkg::StrbWidth);
            off_q  <= '0;
            rem_q  <= rem_q - word_bytes;
        end
        if ((state_q == st_resp) && src_rvalid_i) begin
            rdata_q <= src_rdata_i;
        end
    end

endmodule

//--- hdl/lane_buffer.sv
/*
 * Byte-lane buffer between the read and write ports.
 * Each lane is an independent byte FIFO of BufferDepth entries that
 * keeps its bytes in order. A push shows at the outputs the next cycle.
 */
`timescale 1ns/1ps

module lane_buffer (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  dma_pkg::lane_data_t  in_data_i,
    input  dma_pkg::lane_mask_t  in_valid_i,
    output dma_pkg::lane_mask_t  in_ready_o,
    output dma_pkg::lane_data_t  out_data_o,
    output dma_pkg::lane_mask_t  out_valid_o,
    input  dma_pkg::lane_mask_t  out_ready_i
);

    function automatic dma_pkg::ptr_t next_ptr(dma_pkg::ptr_t ptr);
        return (ptr == dma_pkg::ptr_t'(dma_pkg::BufferDepth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    for (genvar l = 0; l < dma_pkg::StrbWidth; l++) begin : gen_lane
        dma_pkg::byte_t mem_q [dma_pkg::BufferDepth];
        dma_pkg::ptr_t  wptr_q;
        dma_pkg::ptr_t  rptr_q;
        dma_pkg::cnt_t  cnt_q;
        logic           push;
        logic           pop;

        assign in_ready_o[l]  = cnt_q != dma_pkg::cnt_t'(dma_pkg::BufferDepth);
        assign out_valid_o[l] = cnt_q != '0;
        assign out_data_o[l]  = mem_q[rptr_q];

        assign push = in_valid_i[l] && in_ready_o[l];
        assign pop  = out_valid_o[l] && out_ready_i[l];

        always_ff @(posedge clk_i) begin
            if (!rst_n_i) begin
                wptr_q <= '0;
                rptr_q <= '0;
                cnt_q  <= '0;
            end else begin
                if (push) begin
                    wptr_q <= next_ptr(wptr_q);
                end
                if (pop) begin
                    rptr_q <= next_ptr(rptr_q);
                end
                // Push and pop in one cycle leave the count alone
                cnt_q <= cnt_q + dma_pkg::cnt_t'(push) - dma_pkg::cnt_t'(pop);
            end
        end

        always_ff @(posedge clk_i) begin
            if (push) begin
                mem_q[wptr_q] <= in_data_i[l];
            end
        end
    end

endmodule

//--- hdl/write_port.sv
/*
 * Destination writer of the DMA transport.
 * Walks the destination words, waits until every enabled lane of the
 * current word holds a byte, pops them and writes the word over OBI.
 * Disabled lanes carry zero. One write is outstanding at a time, and
 * the next word starts only after its acknowledgement.
 */
`timescale 1ns/1ps

module write_port (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    xfer_desc_if.port            wr_desc,
    input  dma_pkg::lane_data_t  lane_data_i,
    input  dma_pkg::lane_mask_t  lane_valid_i,
    output dma_pkg::lane_mask_t  lane_ready_o,
    output logic                 dst_req_o,
    output dma_pkg::addr_t       dst_addr_o,
    output dma_pkg::lane_mask_t  dst_be_o,
    output dma_pkg::lane_data_t  dst_wdata_o,
    input  logic                 dst_gnt_i,
    input  logic                 dst_rvalid_i
);

    typedef enum logic [1:0] {
        st_idle,
        st_fill,
        st_req,
        st_resp
    } state_e;

    state_e              state_q;
    dma_pkg::addr_t      addr_q;
    dma_pkg::shift_t     off_q;
    dma_pkg::len_t       rem_q;
    dma_pkg::lane_mask_t be_q;
    dma_pkg::lane_data_t wdata_q;

    dma_pkg::lane_mask_t be;
    dma_pkg::len_t       word_bytes;
    dma_pkg::lane_data_t masked_data;
    logic                pop;

    assign be         = dma_pkg::span_mask(off_q, rem_q);
    assign word_bytes = dma_pkg::span_bytes(off_q, rem_q);
    assign pop        = (state_q == st_fill) && ((lane_valid_i & be) == be);

    always_comb begin
        for (int l = 0; l < dma_pkg::StrbWidth; l++) begin
            masked_data[l] = be[l] ? lane_data_i[l] : 8'h00;
        end
    end

    assign lane_ready_o  = pop ? be : '0;
    assign dst_req_o     = state_q == st_req;
    assign dst_addr_o    = addr_q;
    assign dst_be_o      = be_q;
    assign dst_wdata_o   = wdata_q;
    assign wr_desc.ready = state_q == st_idle;
    // Remaining count is already zero once the last word was popped
    assign wr_desc.done  = (state_q == st_resp) && dst_rvalid_i && (rem_q == '0);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= st_idle;
        end else begin
            unique case (state_q)
                st_idle: if (wr_desc.valid) state_q <= st_fill;
                st_fill: if (pop) state_q <= st_req;
                st_req:  if (dst_gnt_i) state_q <= st_resp;
                default: begin
                    if (dst_rvalid_i) begin
                        state_q <= (rem_q == '0) ? st_idle : st_fill;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_desc.valid && wr_desc.ready) begin
            addr_q <= wr_desc.addr & ~dma_pkg::addr_t'(dma_pkg::StrbWidth - 1);
            off_q  <= dma_pkg::shift_t'(wr_desc.addr);
            rem_q  <= wr_desc.length;
        end else if (pop) begin
            off_q   <= '0;
            rem_q   <= rem_q - word_bytes;
            be_q    <= be;
            wdata_q <= masked_data;
        end else if ((state_q == st_resp) && dst_rvalid_i) begin
            addr_q <= addr_q + dma_pkg::addr_t'(dma_pkg::StrbWidth);
        end
    end

endmodule

//--- hdl/dma_transport.sv
/*
 * Single-channel DMA transport datapath.
 * One copy command of 1 to 255 bytes at a time between two OBI memories.
 * Both OBI ports issue word-aligned addresses with at most one access
 * outstanding each. done_o pulses once when the last write is acknowledged.
 */
`timescale 1ns/1ps

module dma_transport (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    // Command
    input  logic                 cmd_valid_i,
    output logic                 cmd_ready_o,
    input  dma_pkg::addr_t       cmd_src_addr_i,
    input  dma_pkg::addr_t       cmd_dst_addr_i,
    input  dma_pkg::len_t        cmd_len_i,
    // Source OBI
    output logic                 src_req_o,
    output dma_pkg::addr_t       src_addr_o,
    input  logic                 src_gnt_i,
    input  logic                 src_rvalid_i,
    input  dma_pkg::lane_data_t  src_rdata_i,
    // Destination OBI
    output logic                 dst_req_o,
    output dma_pkg::addr_t       dst_addr_o,
    output dma_pkg::lane_mask_t  dst_be_o,
    output dma_pkg::lane_data_t  dst_wdata_o,
    input  logic                 dst_gnt_i,
    input  logic                 dst_rvalid_i,
    // Status
    output logic                 busy_o,
    output logic                 done_o
);

    dma_pkg::shift_t     rd_shift;
    dma_pkg::lane_data_t in_data;
    dma_pkg::lane_mask_t in_valid;
    dma_pkg::lane_mask_t in_ready;
    dma_pkg::lane_data_t out_data;
    dma_pkg::lane_mask_t out_valid;
    dma_pkg::lane_mask_t out_ready;

    xfer_desc_if rd_desc ();
    xfer_desc_if wr_desc ();

    xfer_ctrl i_ctrl (
        .clk_i          ( clk_i          ),
        .rst_n_i        ( rst_n_i        ),
        .cmd_valid_i    ( cmd_valid_i    ),
        .cmd_ready_o    ( cmd_ready_o    ),
        .cmd_src_addr_i ( cmd_src_addr_i ),
        .cmd_dst_addr_i ( cmd_dst_addr_i ),
        .cmd_len_i      ( cmd_len_i      ),
        .busy_o         ( busy_o         ),
        .done_o         ( done_o         ),
        .rd_shift_o     ( rd_shift       ),
        .rd_desc        ( rd_desc.ctrl   ),
        .wr_desc        ( wr_desc.ctrl   )
    );

    //----------------------------------------
    // Read, buffer, write
    //----------------------------------------

    read_port i_read_port (
        .clk_i        ( clk_i        ),
        .rst_n_i      ( rst_n_i      ),
        .rd_desc      ( rd_desc.port ),
        .rd_shift_i   ( rd_shift     ),
        .src_req_o    ( src_req_o    ),
        .src_addr_o   ( src_addr_o   ),
        .src_gnt_i    ( src_gnt_i    ),
        .src_rvalid_i ( src_rvalid_i ),
        .src_rdata_i  ( src_rdata_i  ),
        .lane_data_o  ( in_data      ),
        .lane_valid_o ( in_valid     ),
        .lane_ready_i ( in_ready     )
    );

    lane_buffer i_lane_buffer (
        .clk_i       ( clk_i     ),
        .rst_n_i     ( rst_n_i   ),
        .in_data_i   ( in_data   ),
        .in_valid_i  ( in_valid  ),
        .in_ready_o  ( in_ready  ),
        .out_data_o  ( out_data  ),
        .out_valid_o ( out_valid ),
        .out_ready_i ( out_ready )
    );

    write_port i_write_port (
        .clk_i        ( clk_i        ),
        .rst_n_i      ( rst_n_i      ),
        .wr_desc      ( wr_desc.port ),
        .lane_data_i  ( out_data     ),
        .lane_valid_i ( out_valid    ),
        .lane_ready_o ( out_ready    ),
        .dst_req_o    ( dst_req_o    ),
        .dst_addr_o   ( dst_addr_o   ),
        .dst_be_o     ( dst_be_o     ),
        .dst_wdata_o  ( dst_wdata_o  ),
        .dst_gnt_i    ( dst_gnt_i    ),
        .dst_rvalid_i ( dst_rvalid_i )
    );

endmodule

//--- test/dma_transport_properties.sv
/*
 * Protocol checks on the DMA transport top level.
 * OBI request fields must hold until the grant, and status outputs
 * must agree with the command handshake.
 */
`timescale 1ns/1ps

module dma_transport_properties (
    input logic                clk_i,
    input logic                rst_n_i,
    input logic                cmd_ready_o,
    input logic                busy_o,
    input logic                done_o,
    input logic                src_req_o,
    input dma_pkg::addr_t      src_addr_o,
    input logic                src_gnt_i,
    input logic                dst_req_o,
    input dma_pkg::addr_t      dst_addr_o,
    input dma_pkg::lane_mask_t dst_be_o,
    input dma_pkg::lane_data_t dst_wdata_o,
    input logic                dst_gnt_i
);

    //----------------------------------------
    // OBI request stability
    //----------------------------------------

    a_src_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        src_req_o && !src_gnt_i |=> src_req_o && $stable(src_addr_o))
        else $error("source request changed before its grant");

    a_dst_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        dst_req_o && !dst_gnt_i |=> dst_req_o && $stable({dst_addr_o, dst_be_o, dst_wdata_o}))
        else $error("destination request changed before its grant");

    a_dst_be: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        dst_req_o |-> dst_be_o != '0)
        else $error("destination write with no byte enabled");

    //----------------------------------------
    // Status
    //----------------------------------------

    // Ready drops for the whole transfer and returns once idle
    a_ready_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        cmd_ready_o == !busy_o)
        else $error("command ready does not mirror busy");

    // busy falls together with the done pulse
    a_done_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        done_o |-> $past(busy_o))
        else $error("done pulse outside a transfer");

endmodule

bind dma_transport dma_transport_properties i_props (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .cmd_ready_o ( cmd_ready_o ),
    .busy_o      ( busy_o      ),
    .done_o      ( done_o      ),
    .src_req_o   ( src_req_o   ),
    .src_addr_o  ( src_addr_o  ),
    .src_gnt_i   ( src_gnt_i   ),
    .dst_req_o   ( dst_req_o   ),
    .dst_addr_o  ( dst_addr_o  ),
    .dst_be_o    ( dst_be_o    ),
    .dst_wdata_o ( dst_wdata_o ),
    .dst_gnt_i   ( dst_gnt_i   )
);

//--- test/tb_dma_transport.sv
/*
 * Testbench of the DMA transport with two 256-byte OBI memory models.
 * Command addresses and lengths in the table must stay below 256.
 * Both models grant after 0 to 2 cycles and answer 1 to 2 cycles later.
 * Inputs change 2 ns after the rising edge; outputs are sampled there too.
 */
`timescale 1ns/1ps

module tb_dma_transport;

    localparam int unsigned NumCmds       = 9;
    localparam int unsigned TimeoutCycles = 2000;

    typedef struct packed {
        logic [15:0] src;
        logic [15:0] dst;
        logic [7:0]  len;
    } cmd_t;

    logic                clk_i = 1'b0;
    logic                rst_n_i;
    logic                cmd_valid_i;
    logic                cmd_ready_o;
    dma_pkg::addr_t      cmd_src_addr_i;
    dma_pkg::addr_t      cmd_dst_addr_i;
    dma_pkg::len_t       cmd_len_i;
    logic                src_req_o;
    dma_pkg::addr_t      src_addr_o;
    logic                src_gnt_i;
    logic                src_rvalid_i;
    dma_pkg::lane_data_t src_rdata_i;
    logic                dst_req_o;
    dma_pkg::addr_t      dst_addr_o;
    dma_pkg::lane_mask_t dst_be_o;
    dma_pkg::lane_data_t dst_wdata_o;
    logic                dst_gnt_i;
    logic                dst_rvalid_i;
    logic                busy_o;
    logic                done_o;

    integer     seed = 32'hbede;
    logic [7:0] src_mem [256];
    logic [7:0] dst_mem [256];

    // Aligned, misaligned in both directions, single byte and long copies
    cmd_t cmd_table [NumCmds] = '{
        '{16'h0000, 16'h0040, 8'd16},
        '{16'h0011, 16'h0083, 8'd7},
        '{16'h0023, 16'h00a0, 8'd13},
        '{16'h0033, 16'h0050, 8'd1},
        '{16'h0042, 16'h0001, 8'd13},
        '{16'h0005, 16'h0096, 8'd64},
        '{16'h0080, 16'h0020, 8'd64},
        '{16'h0067, 16'h00c2, 8'd33},
        '{16'h00bf, 16'h003d, 8'd64}
    };

    always #10 clk_i = ~clk_i;

    dma_transport i_dut (.*);

    //----------------------------------------
    // Helpers
    //----------------------------------------

    task automatic next_cycle();
        @(posedge clk_i);
        #2;
    endtask

    function automatic int unsigned rand_below(int unsigned bound);
        return $unsigned($random(seed)) % bound;
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string name);
        if (actual !== expected) begin
            $display("FAIL time=%0t %s: actual 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
            $display("Test failed");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("Test failed");
        $fatal(1, "Timed out waiting for %s", what);
    endtask

    //----------------------------------------
    // OBI memory models
    //----------------------------------------

    initial begin : src_model
        logic [7:0] base;
        src_gnt_i    = 1'b0;
        src_rvalid_i = 1'b0;
        src_rdata_i  = '0;
        forever begin
            next_cycle();
            if (src_req_o === 1'b1) begin
                repeat (rand_below(3)) next_cycle();
                src_gnt_i = 1'b1;
                base      = src_addr_o[7:0];
                check_value(32'(src_addr_o[1:0]), 32'h0, "src_addr_o[1:0]");
                next_cycle();
                src_gnt_i = 1'b0;
                repeat (rand_below(2)) next_cycle();
                src_rvalid_i = 1'b1;
                for (int l = 0; l < 4; l++) begin
                    src_rdata_i[l] = src_mem[base + 8'(l)];
                end
                next_cycle();
                src_rvalid_i = 1'b0;
                // Read data means nothing once rvalid is low
                src_rdata_i  = $random(seed);
            end
        end
    end

    initial begin : dst_model
        dst_gnt_i    = 1'b0;
        dst_rvalid_i = 1'b0;
        forever begin
            next_cycle();
            if (dst_req_o === 1'b1) begin
                repeat (rand_below(3)) next_cycle();
                dst_gnt_i = 1'b1;
                check_value(32'(dst_addr_o[1:0]), 32'h0, "dst_addr_o[1:0]");
                for (int l = 0; l < 4; l++) begin
                    if (dst_be_o[l]) begin
                        dst_mem[dst_addr_o[7:0] + 8'(l)] = dst_wdata_o[l];
                    end else begin
                        check_value(32'(dst_wdata_o[l]), 32'h0, "dst_wdata_o disabled lane");
                    end
                end
                next_cycle();
                dst_gnt_i = 1'b0;
                repeat (rand_below(2)) next_cycle();
                dst_rvalid_i = 1'b1;
                next_cycle();
                dst_rvalid_i = 1'b0;
            end
        end
    end

    //----------------------------------------
    // Command sequencing
    //----------------------------------------

    task automatic wait_cmd_ready();
        int unsigned cycles;
        cycles = 0;
        while (cmd_ready_o !== 1'b1) begin
            next_cycle();
            cycles++;
            if (cycles > TimeoutCycles) timeout_fail("cmd_ready_o");
        end
    endtask

    // busy_o must stay high for the whole transfer
    task automatic wait_done();
        int unsigned cycles;
        cycles = 0;
        while (done_o !== 1'b1) begin
            check_value(32'(busy_o), 32'h1, "busy_o");
            next_cycle();
            cycles++;
            if (cycles > TimeoutCycles) timeout_fail("done_o");
        end
    endtask

    task automatic run_command(input cmd_t cmd);
        wait_cmd_ready();
        cmd_valid_i    = 1'b1;
        cmd_src_addr_i = cmd.src;
        cmd_dst_addr_i = cmd.dst;
        cmd_len_i      = cmd.len;
        next_cycle();
        cmd_valid_i = 1'b0;
        check_value(32'(busy_o), 32'h1, "busy_o");
        check_value(32'(cmd_ready_o), 32'h0, "cmd_ready_o");
        wait_done();
        check_value(32'(busy_o), 32'h0, "busy_o");
        next_cycle();
        check_value(32'(done_o), 32'h0, "done_o");
        check_value(32'(busy_o), 32'h0, "busy_o");
    endtask

    // Copied range matches the source, everything else keeps the fill
    task automatic verify_memory(input cmd_t cmd);
        int         s;
        int         d;
        int         n;
        logic [7:0] expected;
        s = int'(cmd.src);
        d = int'(cmd.dst);
        n = int'(cmd.len);
        for (int a = 0; a < 256; a++) begin
            if (a >= d && a < d + n) begin
                expected = src_mem[s + a - d];
            end else begin
                expected = 8'hee;
            end
            check_value(32'(dst_mem[a]), 32'(expected), $sformatf("dst_mem[0x%02h]", a));
        end
    endtask

    initial begin : main
        rst_n_i        = 1'b0;
        cmd_valid_i    = 1'b0;
        cmd_src_addr_i = '0;
        cmd_dst_addr_i = '0;
        cmd_len_i      = '0;
        for (int i = 0; i < 256; i++) begin
            src_mem[i] = 8'($random(seed));
            dst_mem[i] = 8'hee;
        end
        repeat (10) @(posedge clk_i);
        #2;
        rst_n_i = 1'b1;

        check_value(32'(busy_o), 32'h0, "busy_o");
        check_value(32'(cmd_ready_o), 32'h1, "cmd_ready_o");
        check_value(32'(done_o), 32'h0, "done_o");
        check_value(32'(src_req_o), 32'h0, "src_req_o");
        check_value(32'(dst_req_o), 32'h0, "dst_req_o");

        for (int c = 0; c < NumCmds; c++) begin
            for (int i = 0; i < 256; i++) begin
                dst_mem[i] = 8'hee;
            end
            run_command(cmd_table[c]);
            verify_memory(cmd_table[c]);
        end

        $display("Test passed");
        $finish;
    end

endmodule

//--- verilog.f
hdl/dma_pkg.sv
hdl/xfer_desc_if.sv
hdl/xfer_ctrl.sv
hdl/read_port.sv
hdl/lane_buffer.sv
hdl/write_port.sv
hdl/dma_transport.sv
test/dma_transport_properties.sv
test/tb_dma_transport.sv

//--- run.sh
#!/bin/sh
# Build and run the DMA transport testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_dma_transport \
    -f verilog.f \
    -Mdir obj_dir \
    -o sim_dma_transport

./obj_dir/sim_dma_transport
